// File: bt_receiver_params.svh
// Receive path constants
// FIFO capacity, framing byte codes and the app order code

`ifndef BT_RECEIVER_PARAMS_SVH
`define BT_RECEIVER_PARAMS_SVH

// Receive FIFO capacity in bytes
// Must be even and a power of two, pointers wrap freely
`define RX_FIFO_DEPTH_BYTES 64

// Line feed closes an AT reply
`define AT_END_BYTE 8'h0A

// App command frame marker and terminator
`define CMD_START_BYTE 8'h11
`define CMD_END_BYTE 8'h00

// Order field value in bits 6 to 4
// Low three bits then carry the stream number
`define SELECT_DATASTREAM 3'b110

`endif

// File: bt_receiver_pkg.sv
// Shared types for the receive path
// Vector widths, received byte and FIFO status structs, parser states

`default_nettype none

package bt_receiver_pkg;

	// One serial byte
	typedef logic [7:0] byte_t;
	// FIFO output word, first byte in the upper half
	typedef logic [15:0] word_t;
	// Clock cycles per serial bit
	typedef logic [9:0] bit_cycles_t;
	// Bytes held, up to the full depth
	typedef logic [6:0] wr_count_t;
	// Complete words held
	typedef logic [5:0] rd_count_t;
	typedef logic [2:0] stream_sel_t;

	// Byte from the UART, valid for one cycle
	typedef struct packed {
		byte_t data;
		logic  valid;
	} rx_byte_s;

	typedef struct packed {
		logic      full;
		logic      empty;
		wr_count_t wr_count;
		rd_count_t rd_count;
	} fifo_status_s;

	// Session level
	typedef enum logic [1:0] {
		idle,
		collect_at,
		get_command,
		apply_order
	} session_e;

	// Position inside an app command frame
	typedef enum logic [1:0] {
		wait_marker,
		take_order,
		wait_end
	} frame_e;

endpackage

`default_nettype wire

// File: uart_rx.sv
// UART receiver, 8 data bits, no parity, one stop bit
// Input synchronizer, mid-bit sampling, busy level and byte strobe

`timescale 1ns/1ps
`default_nettype none

module uart_rx
	import bt_receiver_pkg::*;
(
	input  logic        clock,
	input  logic        reset,
	input  bit_cycles_t cycles_per_bit,
	input  logic        rxd,
	output rx_byte_s    rx_byte,
	output logic        busy
);

	typedef enum logic [1:0] {
		rx_idle,
		rx_start,
		rx_data,
		rx_stop
	} rx_state_e;

	rx_state_e   state;
	logic [1:0]  rxd_sync;
	logic        line;
	logic        line_prev;
	logic        line_fall;
	bit_cycles_t bit_cnt;
	bit_cycles_t bit_end;
	bit_cycles_t half_end;
	logic        bit_done;
	logic        half_done;
	logic [2:0]  bit_idx;
	byte_t       shift_q;
	logic        valid_q;

	// Two flops against metastability, idle line is high
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			rxd_sync  <= 2'b11;
			line_prev <= 1'b1;
		end
		else
		begin
			rxd_sync  <= {rxd_sync[0], rxd};
			line_prev <= line;
		end
	end

	assign line      = rxd_sync[1];
	assign line_fall = line_prev & ~line;

	assign bit_end   = cycles_per_bit - 10'd1;
	assign half_end  = (cycles_per_bit >> 1) - 10'd1;
	assign bit_done  = (bit_cnt == bit_end);
	assign half_done = (bit_cnt == half_end);

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			state   <= rx_idle;
			bit_cnt <= '0;
			bit_idx <= '0;
			valid_q <= 1'b0;
		end
		else
		begin
			valid_q <= 1'b0;
			case (state)
				rx_idle:
				begin
					bit_cnt <= '0;
					bit_idx <= '0;
					if (line_fall)
						state <= rx_start;
				end
				rx_start:
				begin
					// Start bit must still be low at mid-bit
					if (half_done)
					begin
						bit_cnt <= '0;
						state   <= line ? rx_idle : rx_data;
					end
					else
						bit_cnt <= bit_cnt + 10'd1;
				end
				rx_data:
				begin
					if (bit_done)
					begin
						bit_cnt <= '0;
						bit_idx <= bit_idx + 3'd1;
						if (bit_idx == 3'd7)
							state <= rx_stop;
					end
					else
						bit_cnt <= bit_cnt + 10'd1;
				end
				default:
				begin
					// Framing error drops the byte silently
					if (bit_done)
					begin
						valid_q <= line;
						state   <= rx_idle;
					end
					else
						bit_cnt <= bit_cnt + 10'd1;
				end
			endcase
		end
	end

	// LSB arrives first
	always_ff @(posedge clock)
	begin
		if (state == rx_data && bit_done)
			shift_q <= {line, shift_q[7:1]};
	end

	assign rx_byte.data  = shift_q;
	assign rx_byte.valid = valid_q;
	assign busy          = (state != rx_idle);

endmodule

`default_nettype wire

// File: rx_fifo.sv
// Receive FIFO, bytes in and 16-bit words out
// Oldest complete word shown ahead, byte and word counts, full and empty

`timescale 1ns/1ps
`default_nettype none

`include "bt_receiver_params.svh"

module rx_fifo
	import bt_receiver_pkg::*;
(
	input  logic         clock,
	input  logic         reset,
	input  logic         wr_en,
	input  byte_t        wr_data,
	input  logic         rd_en,
	output word_t        rd_data,
	output fifo_status_s status
);

	localparam int ADDR_W = $clog2(`RX_FIFO_DEPTH_BYTES);
	localparam wr_count_t DEPTH = wr_count_t'(`RX_FIFO_DEPTH_BYTES);

	byte_t             mem [`RX_FIFO_DEPTH_BYTES];
	logic [ADDR_W-1:0] wr_ptr;
	logic [ADDR_W-1:0] rd_ptr;
	logic [ADDR_W-1:0] rd_ptr_hi;
	wr_count_t         byte_count;
	rd_count_t         word_count;
	logic              full;
	logic              empty;
	logic              do_write;
	logic              do_read;

	// Only whole pairs can be read, an odd last byte waits
	assign word_count = rd_count_t'(byte_count >> 1);
	assign full       = (byte_count == DEPTH);
	assign empty      = (byte_count == '0);

	// Writes into a full FIFO are lost
	assign do_write = wr_en & ~full;
	assign do_read  = rd_en & (word_count != '0);

	always_ff @(posedge clock)
	begin
		if (do_write)
			mem[wr_ptr] <= wr_data;
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			byte_count <= '0;
		end
		else
		begin
			if (do_write)
				wr_ptr <= wr_ptr + 1'b1;
			// Read pointer always stays on an even address
			if (do_read)
				rd_ptr <= rd_ptr + 2'd2;
			byte_count <= byte_count + wr_count_t'(do_write)
				- wr_count_t'({do_read, 1'b0});
		end
	end

	// Word view of the two oldest bytes
	assign rd_ptr_hi = rd_ptr + 1'b1;
	assign rd_data   = {mem[rd_ptr], mem[rd_ptr_hi]};

	assign status.full     = full;
	assign status.empty    = empty;
	assign status.wr_count = byte_count;
	assign status.rd_count = word_count;

endmodule

`default_nettype wire

// File: command_parser.sv
// Session controller for the Bluetooth receive path
// Session and frame FSMs, AT completion, order register, stream selector

`timescale 1ns/1ps
`default_nettype none

`include "bt_receiver_params.svh"

module command_parser
	import bt_receiver_pkg::*;
(
	input  logic        clock,
	input  logic        reset,
	input  rx_byte_s    rx_byte,
	input  logic        busy,
	input  logic        bt_state,
	output logic        fifo_wr_en,
	output logic        at_complete,
	output logic        set_sending,
	output stream_sel_t stream_select
);

	session_e session;
	session_e session_next;
	frame_e   frame;
	frame_e   frame_next;
	byte_t    order;
	logic     byte_valid;
	logic     is_at_end;
	logic     is_marker;
	logic     is_cmd_end;
	logic     order_load;

	assign byte_valid = rx_byte.valid;
	assign is_at_end  = (rx_byte.data == `AT_END_BYTE);
	assign is_marker  = (rx_byte.data == `CMD_START_BYTE);
	assign is_cmd_end = (rx_byte.data == `CMD_END_BYTE);

	// Session picks its path from bt_state when the first byte starts
	always_comb
	begin
		session_next = session;
		frame_next   = frame;
		case (session)
			idle:
			begin
				if (busy)
					session_next = bt_state ? get_command : collect_at;
			end
			collect_at:
			begin
				if (byte_valid && is_at_end)
					session_next = idle;
			end
			get_command:
			begin
				case (frame)
					wait_marker:
					begin
						// Anything ahead of the marker is noise
						if (byte_valid && is_marker)
							frame_next = take_order;
					end
					take_order:
					begin
						if (byte_valid)
							frame_next = wait_end;
					end
					default:
					begin
						if (byte_valid && is_cmd_end)
						begin
							frame_next   = wait_marker;
							session_next = apply_order;
						end
					end
				endcase
			end
			default:
				session_next = idle;
		endcase
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			session     <= idle;
			frame       <= wait_marker;
			at_complete <= 1'b0;
		end
		else
		begin
			session     <= session_next;
			frame       <= frame_next;
			// One cycle after the line feed strobe
			at_complete <= (session == collect_at) & byte_valid & is_at_end;
		end
	end

	// Order byte follows the marker
	assign order_load = (session == get_command) & (frame == take_order) & byte_valid;

	always_ff @(posedge clock)
	begin
		if (order_load)
			order <= rx_byte.data;
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
			stream_select <= '0;
		else if (session == apply_order && order[6:4] == `SELECT_DATASTREAM)
			stream_select <= order[2:0];
	end

	// AT reply bytes go to the FIFO, command bytes do not
	assign fifo_wr_en = byte_valid & (session == collect_at);

	// Sending paused while a command is handled
	assign set_sending = ~((session == get_command) | (session == apply_order));

endmodule

`default_nettype wire

// File: bt_receiver.sv
// Top level of the Bluetooth receive path
// UART receiver, session controller and receive FIFO

`timescale 1ns/1ps
`default_nettype none

module bt_receiver
	import bt_receiver_pkg::*;
(
	input  logic         clock,
	input  logic         reset,
	input  bit_cycles_t  cycles_per_bit,
	input  logic         rxd,
	input  logic         bt_state,
	input  logic         fifo_rd_en,
	output word_t        fifo_data,
	output fifo_status_s fifo_status,
	output logic         at_complete,
	output logic         set_sending,
	output stream_sel_t  stream_select
);

	rx_byte_s rx_byte;
	logic     rx_busy;
	logic     fifo_wr_en;

	uart_rx uart_rx_i (
		.clock          (clock),
		.reset          (reset),
		.cycles_per_bit (cycles_per_bit),
		.rxd            (rxd),
		.rx_byte        (rx_byte),
		.busy           (rx_busy)
	);

	command_parser command_parser_i (
		.clock         (clock),
		.reset         (reset),
		.rx_byte       (rx_byte),
		.busy          (rx_busy),
		.bt_state      (bt_state),
		.fifo_wr_en    (fifo_wr_en),
		.at_complete   (at_complete),
		.set_sending   (set_sending),
		.stream_select (stream_select)
	);

	// Write strobe already qualified by the parser
	rx_fifo rx_fifo_i (
		.clock   (clock),
		.reset   (reset),
		.wr_en   (fifo_wr_en),
		.wr_data (rx_byte.data),
		.rd_en   (fifo_rd_en),
		.rd_data (fifo_data),
		.status  (fifo_status)
	);

endmodule

`default_nettype wire

// File: bt_receiver_props.sv
// Assertions bound to the receive path top level
// AT completion pulse width, FIFO flags, stream selector stability

`timescale 1ns/1ps
`default_nettype none

module bt_receiver_props
	import bt_receiver_pkg::*;
(
	input logic         clock,
	input logic         reset,
	input logic         at_complete,
	input logic         set_sending,
	input stream_sel_t  stream_select,
	input fifo_status_s fifo_status
);

	int assert_failures = 0;

	// Completion is a single-cycle strobe
	at_complete_single: assert property (
		@(posedge clock) disable iff (reset)
		at_complete |=> !at_complete
	)
	else
	begin
		$error("at_complete stayed high for two cycles");
		assert_failures++;
	end

	fifo_flags_exclusive: assert property (
		@(posedge clock) disable iff (reset)
		!(fifo_status.full && fifo_status.empty)
	)
	else
	begin
		$error("FIFO full and empty at the same time");
		assert_failures++;
	end

	// Selector moves only inside a command or as sending resumes
	stream_select_stable: assert property (
		@(posedge clock) disable iff (reset)
		$changed(stream_select) |-> (!set_sending || $rose(set_sending))
	)
	else
	begin
		$error("stream_select changed while sending was enabled");
		assert_failures++;
	end

endmodule

bind bt_receiver bt_receiver_props bt_receiver_props_i (
	.clock         (clock),
	.reset         (reset),
	.at_complete   (at_complete),
	.set_sending   (set_sending),
	.stream_select (stream_select),
	.fifo_status   (fifo_status)
);

`default_nettype wire

// File: tb_bt_receiver.sv
// Testbench for the Bluetooth receive path
// Serial byte driver, stimulus table, FIFO byte model and closing report

`timescale 1ns/1ps
`default_nettype none

`include "bt_receiver_params.svh"

module tb_bt_receiver
	import bt_receiver_pkg::*;
();

	localparam int BIT_CYCLES = 16;
	localparam int WAIT_LIMIT = 500;
	localparam int DEPTH = `RX_FIFO_DEPTH_BYTES;

	// Bytes go out from bits 63 to 56 first
	typedef struct packed {
		logic        connected;
		logic [63:0] bytes;
		logic [3:0]  count;
		stream_sel_t exp_stream;
		logic [6:0]  exp_added;
		logic [1:0]  exp_at_done;
	} stim_entry_t;

	logic         clock;
	logic         reset;
	bit_cycles_t  cycles_per_bit;
	logic         rxd;
	logic         bt_state;
	logic         fifo_rd_en;
	word_t        fifo_data;
	fifo_status_s fifo_status;
	logic         at_complete;
	logic         set_sending;
	stream_sel_t  stream_select;

	stim_entry_t stim_table [5];
	byte_t       model_bytes [$];
	byte_t       session_bytes [$];
	int          errors = 0;
	int          at_pulses = 0;
	int          low_cycles = 0;
	int          seed = 58;

	bt_receiver bt_receiver_i (.*);

	initial
	begin
		clock = 1'b0;
		forever
			#50 clock = ~clock;
	end

	// Pulse and level counters over the whole run
	always @(posedge clock)
	begin
		if (!reset && at_complete)
			at_pulses++;
		if (!reset && !set_sending)
			low_cycles++;
	end

	task automatic check_value(input string what, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
		begin
			errors++;
			$display("Mismatch at %0t ns: %s is 0x%0h, expected 0x%0h",
				$time, what, actual, expected);
		end
	endtask

	// 8N1 frame with the LSB first
	task automatic send_byte(input byte_t value);
		logic [9:0] frame;
		int i;
		frame = {1'b1, value, 1'b0};
		for (i = 0; i < 10; i++)
		begin
			@(posedge clock);
			rxd <= frame[i];
			repeat (BIT_CYCLES - 1)
				@(posedge clock);
		end
	endtask

	function automatic byte_t random_payload();
		byte_t value;
		value = byte_t'($random(seed));
		// Keep clear of the framing codes
		if (value == `AT_END_BYTE || value == `CMD_START_BYTE || value == `CMD_END_BYTE)
			value = value ^ 8'h40;
		return value;
	endfunction

	// Pops every complete word and compares it with the byte model
	task automatic drain_words();
		word_t expected_word;
		int reads;
		reads = 0;
		@(negedge clock);
		while (fifo_status.rd_count != 0 && model_bytes.size() >= 2 && reads < DEPTH)
		begin
			expected_word[15:8] = model_bytes.pop_front();
			expected_word[7:0] = model_bytes.pop_front();
			check_value("fifo_data", fifo_data, expected_word);
			@(posedge clock);
			fifo_rd_en <= 1'b1;
			@(posedge clock);
			fifo_rd_en <= 1'b0;
			@(negedge clock);
			reads++;
		end
		check_value("rd_count after reads", fifo_status.rd_count, 0);
		check_value("wr_count after reads", fifo_status.wr_count, model_bytes.size());
		check_value("empty after reads", fifo_status.empty, model_bytes.size() == 0);
	endtask

	task automatic run_session(input logic connected, input stream_sel_t exp_stream,
		input int exp_added, input int exp_at_done);
		int at_before;
		int low_before;
		int expected_bytes;
		int cycles;
		@(posedge clock);
		bt_state <= connected;
		at_before = at_pulses;
		low_before = low_cycles;
		expected_bytes = model_bytes.size() + exp_added;
		foreach (session_bytes[i])
		begin
			send_byte(session_bytes[i]);
			// AT bytes land in the FIFO until it fills
			if (!connected && model_bytes.size() < DEPTH)
				model_bytes.push_back(session_bytes[i]);
		end
		cycles = 0;
		while ((at_pulses < at_before + exp_at_done || !set_sending) && cycles < WAIT_LIMIT)
		begin
			@(posedge clock);
			cycles++;
		end
		if (at_pulses < at_before + exp_at_done || !set_sending)
		begin
			$display("Timeout at %0t ns: session did not end with sending enabled", $time);
			$display("Check errors: %0d", errors);
			$display("Finished with errors");
			$finish;
		end
		else
		begin
			@(negedge clock);
			check_value("wr_count", fifo_status.wr_count, expected_bytes);
			check_value("rd_count", fifo_status.rd_count, expected_bytes / 2);
			check_value("full", fifo_status.full, expected_bytes == DEPTH);
			check_value("stream_select", stream_select, exp_stream);
			check_value("at_complete pulses", at_pulses - at_before, exp_at_done);
			check_value("set_sending low seen", low_cycles != low_before, connected);
			drain_words();
		end
	endtask

	initial
	begin
		int idx;
		int len;
		int i;
		int assert_failures;
		reset = 1'b1;
		rxd = 1'b1;
		bt_state = 1'b0;
		fifo_rd_en = 1'b0;
		cycles_per_bit = bit_cycles_t'(BIT_CYCLES);
		repeat (2)
			@(posedge clock);
		reset <= 1'b0;
		@(negedge clock);
		check_value("stream_select after reset", stream_select, 3'd0);
		check_value("set_sending after reset", set_sending, 1'b1);
		check_value("at_complete after reset", at_complete, 1'b0);
		check_value("empty after reset", fifo_status.empty, 1'b1);
		check_value("counts after reset", {fifo_status.wr_count, fifo_status.rd_count}, 0);

		// Fixed frames first, then two random AT replies
		// Non-selecting order comes while the selector is still 0
		stim_table[0] = '{1'b0, 64'h4F4B0D0A_00000000, 4'd4, 3'd0, 7'd4, 2'd1};
		stim_table[1] = '{1'b1, 64'h3C631125_00000000, 4'd5, 3'd0, 7'd0, 2'd0};
		stim_table[2] = '{1'b1, 64'h116500_0000000000, 4'd3, 3'd5, 7'd0, 2'd0};
		for (idx = 3; idx < 5; idx++)
		begin
			len = 2 + ($unsigned($random(seed)) % 7);
			stim_table[idx] = '{1'b0, 64'h0, len[3:0], 3'd5, len[6:0], 2'd1};
			for (i = 0; i < len - 1; i++)
				stim_table[idx].bytes[63 - 8 * i -: 8] = random_payload();
			stim_table[idx].bytes[63 - 8 * (len - 1) -: 8] = `AT_END_BYTE;
		end

		for (idx = 0; idx < 5; idx++)
		begin
			session_bytes.delete();
			for (i = 0; i < stim_table[idx].count; i++)
				session_bytes.push_back(stim_table[idx].bytes[63 - 8 * i -: 8]);
			run_session(stim_table[idx].connected, stim_table[idx].exp_stream,
				stim_table[idx].exp_added, stim_table[idx].exp_at_done);
		end

		// Overlong AT reply loses the bytes past the depth
		session_bytes.delete();
		for (i = 0; i < DEPTH + 5; i++)
			session_bytes.push_back(random_payload());
		session_bytes.push_back(`AT_END_BYTE);
		run_session(1'b0, 3'd5, DEPTH - model_bytes.size(), 1);

		@(negedge clock);
		assert_failures = bt_receiver_i.bt_receiver_props_i.assert_failures;
		$display("Check errors: %0d, assertion failures: %0d", errors, assert_failures);
		if (errors == 0 && assert_failures == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

// File: bt_receiver.f
+incdir+.
bt_receiver_pkg.sv
uart_rx.sv
rx_fifo.sv
command_parser.sv
bt_receiver.sv
bt_receiver_props.sv
tb_bt_receiver.sv
